// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - files:
      - rtl/exe_pkg.sv
      - rtl/exe_alu.sv
      - rtl/exe_branch_unit.sv
      - rtl/exe_lane.sv
      - rtl/exe_mem_reg.sv
      - rtl/exe_stage.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_exe_stage.sv

// ==== all.f ====
rtl/exe_pkg.sv
rtl/exe_alu.sv
rtl/exe_branch_unit.sv
rtl/exe_lane.sv
rtl/exe_mem_reg.sv
rtl/exe_stage.sv
dv/tb_clk_gen.sv
dv/tb_exe_stage.sv

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// ==== dv/tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage import exe_pkg::*; ();

    logic       clk;
    logic       arst_n;
    logic       pause;
    logic       flush;
    logic [1:0] valid;
    logic [1:0] rd_we;
    logic [1:0] pred_taken;
    alu_op_e    op [2];
    word_t      pc [2];
    word_t      src_a [2];
    word_t      src_b [2];
    word_t      imm [2];
    word_t      pred_tgt [2];
    reg_addr_t  rd [2];

    logic [1:0] bpu_is_branch, bpu_taken, fwd_we, mem_valid, mem_rd_we;
    logic       branch_flush;
    word_t      bpu_target0, bpu_target1, branch_target;
    word_t      fwd_data0, fwd_data1, mem_pc0, mem_pc1, mem_res0, mem_res1;
    reg_addr_t  fwd_rd0, fwd_rd1, mem_rd0, mem_rd1;
    alu_op_e    mem_op0, mem_op1;

    // expectations of the bundle in flight
    logic [1:0] exp_valid;
    logic [1:0] exp_we;
    logic [1:0] exp_mp;
    word_t      exp_res [2];

    int         errors;
    int         checks;
    logic       timed_out;
    word_t      rng_state;

    tb_clk_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    exe_stage u_exe_stage (
        .clk (clk), .arst_n_i (arst_n), .pause_i (pause), .flush_i (flush),
        .valid_i (valid), .op0_i (op[0]), .op1_i (op[1]), .pc0_i (pc[0]), .pc1_i (pc[1]),
        .src_a0_i (src_a[0]), .src_b0_i (src_b[0]), .src_a1_i (src_a[1]), .src_b1_i (src_b[1]),
        .imm0_i (imm[0]), .imm1_i (imm[1]), .rd_we_i (rd_we), .rd0_i (rd[0]), .rd1_i (rd[1]),
        .pred_taken_i (pred_taken), .pred_target0_i (pred_tgt[0]), .pred_target1_i (pred_tgt[1]),
        .bpu_is_branch_o (bpu_is_branch), .bpu_taken_o (bpu_taken),
        .bpu_target0_o (bpu_target0), .bpu_target1_o (bpu_target1),
        .branch_flush_o (branch_flush), .branch_target_o (branch_target),
        .fwd_we_o (fwd_we), .fwd_rd0_o (fwd_rd0), .fwd_rd1_o (fwd_rd1),
        .fwd_data0_o (fwd_data0), .fwd_data1_o (fwd_data1),
        .mem_valid_o (mem_valid), .mem_op0_o (mem_op0), .mem_op1_o (mem_op1),
        .mem_pc0_o (mem_pc0), .mem_pc1_o (mem_pc1), .mem_rd_we_o (mem_rd_we),
        .mem_rd0_o (mem_rd0), .mem_rd1_o (mem_rd1), .mem_res0_o (mem_res0), .mem_res1_o (mem_res1)
    );

    function word_t xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // signed compare built from the sign bits
    function automatic logic signed_less(word_t a, word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic word_t model_result(alu_op_e o, word_t p, word_t a, word_t b);
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOR:  return ~(a | b);
            OP_SLT:  return {31'd0, signed_less(a, b)};
            OP_SLTU: return {31'd0, a < b};
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            OP_LUI:  return b;
            OP_BL, OP_JIRL: return p + INST_BYTES; // return address
            default: return '0;
        endcase
    endfunction

    function automatic logic model_is_branch(alu_op_e o);
        return (o >= OP_BEQ) && (o <= OP_JIRL);
    endfunction

    function automatic logic model_taken(alu_op_e o, word_t a, word_t b);
        case (o)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return signed_less(a, b);
            OP_BGE:  return !signed_less(a, b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            OP_B, OP_BL, OP_JIRL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t model_target(alu_op_e o, word_t p, word_t a, word_t im);
        return (o == OP_JIRL) ? a + im : p + im;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input alu_op_e got, input alu_op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // miss[0] flips the predicted direction, miss[1] spoils the predicted target
    task set_lane(input int l, input alu_op_e o, input word_t a, input word_t b,
                  input logic [1:0] miss);
        word_t p;
        word_t im;
        p  = xorshift() & ~32'h3;
        im = xorshift() & 32'h0000_fffc;
        valid[l]      <= 1'b1;
        rd_we[l]      <= 1'b1;
        op[l]         <= o;
        pc[l]         <= p;
        src_a[l]      <= a;
        src_b[l]      <= b;
        imm[l]        <= im;
        rd[l]         <= reg_addr_t'(xorshift());
        pred_taken[l] <= model_taken(o, a, b) ^ miss[0];
        pred_tgt[l]   <= model_target(o, p, a, im) ^ (miss[1] ? 32'h40 : 32'h0);
    endtask

    task automatic check_comb();
        logic [1:0] br;
        logic [1:0] tk;
        word_t      tgt [2];
        word_t      act [2];
        @(negedge clk); // inputs settled
        for (int l = 0; l < 2; l++) begin
            br[l]        = valid[l] & model_is_branch(op[l]);
            tk[l]        = model_taken(op[l], src_a[l], src_b[l]);
            tgt[l]       = model_target(op[l], pc[l], src_a[l], imm[l]);
            act[l]       = tk[l] ? tgt[l] : pc[l] + INST_BYTES;
            exp_res[l]   = model_result(op[l], pc[l], src_a[l], src_b[l]);
            exp_valid[l] = valid[l];
            exp_we[l]    = valid[l] & rd_we[l];
            exp_mp[l]    = br[l] & ((pred_taken[l] != tk[l])
                           | (pred_taken[l] & tk[l] & (pred_tgt[l] != tgt[l])));
        end
        check_word("fwd_data0_o", fwd_data0, exp_res[0]);
        check_word("fwd_data1_o", fwd_data1, exp_res[1]);
        check_bit("fwd_we_o[0]", fwd_we[0], exp_we[0]);
        check_bit("fwd_we_o[1]", fwd_we[1], exp_we[1]);
        check_reg("fwd_rd0_o", fwd_rd0, rd[0]);
        check_reg("fwd_rd1_o", fwd_rd1, rd[1]);
        check_bit("bpu_is_branch_o[0]", bpu_is_branch[0], br[0]);
        check_bit("bpu_is_branch_o[1]", bpu_is_branch[1], br[1]);
        if (br[0]) begin
            check_bit("bpu_taken_o[0]", bpu_taken[0], tk[0]);
            check_word("bpu_target0_o", bpu_target0, act[0]);
        end
        if (br[1]) begin
            check_bit("bpu_taken_o[1]", bpu_taken[1], tk[1]);
            check_word("bpu_target1_o", bpu_target1, act[1]);
        end
        check_bit("branch_flush_o", branch_flush, (|exp_mp) & ~pause);
        if (|exp_mp) begin
            check_word("branch_target_o", branch_target, exp_mp[0] ? act[0] : act[1]);
        end
    endtask

    task automatic check_mem();
        @(posedge clk);
        valid <= 2'b00; // one-cycle strobe
        @(negedge clk);
        check_bit("mem_valid_o[0]", mem_valid[0], exp_valid[0]);
        check_bit("mem_valid_o[1]", mem_valid[1], exp_valid[1] & ~exp_mp[0]);
        check_bit("mem_rd_we_o[0]", mem_rd_we[0], exp_we[0]);
        check_bit("mem_rd_we_o[1]", mem_rd_we[1], exp_we[1] & ~exp_mp[0]);
        check_word("mem_res0_o", mem_res0, exp_res[0]);
        check_word("mem_res1_o", mem_res1, exp_res[1]);
        check_op("mem_op0_o", mem_op0, op[0]);
        check_op("mem_op1_o", mem_op1, op[1]);
        check_word("mem_pc0_o", mem_pc0, pc[0]);
        check_word("mem_pc1_o", mem_pc1, pc[1]);
        check_reg("mem_rd0_o", mem_rd0, rd[0]);
        check_reg("mem_rd1_o", mem_rd1, rd[1]);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("reset was not released within 20 clock cycles");
        end
    endtask

    // no rising edge since the release, so this is still the reset value
    task automatic test_reset_state();
        check_bit("mem_valid_o[0]", mem_valid[0], 1'b0);
        check_bit("mem_valid_o[1]", mem_valid[1], 1'b0);
        check_bit("mem_rd_we_o[0]", mem_rd_we[0], 1'b0);
        check_bit("mem_rd_we_o[1]", mem_rd_we[1], 1'b0);
        check_bit("branch_flush_o", branch_flush, 1'b0);
    endtask

    task automatic test_alu_random();
        for (int i = 0; i < 24; i++) begin
            @(posedge clk);
            set_lane(0, alu_op_e'(OP_ADD + xorshift() % 12), xorshift(), xorshift(), 2'b00);
            set_lane(1, alu_op_e'(OP_ADD + xorshift() % 12), xorshift(), xorshift(), 2'b00);
            check_comb();
            check_mem();
        end
    endtask

    task automatic test_branch_predicted();
        word_t a;
        for (int i = 0; i < 18; i++) begin
            a = xorshift();
            @(posedge clk);
            // odd rounds use equal operands so both directions show up
            set_lane(0, alu_op_e'(OP_BEQ + i % 9), a, (i % 2) ? a : xorshift(), 2'b00);
            set_lane(1, alu_op_e'(OP_JIRL - i % 9), xorshift(), a, 2'b00);
            check_comb();
            check_mem();
        end
    endtask

    task automatic test_mispredict();
        word_t x;
        x = xorshift();
        @(posedge clk);
        set_lane(0, OP_BEQ, x, x, 2'b01); // taken, predicted not taken
        set_lane(1, OP_ADD, xorshift(), xorshift(), 2'b00);
        check_comb();
        check_mem();
        @(posedge clk);
        set_lane(0, OP_B, x, x, 2'b10); // taken both ways, wrong target
        set_lane(1, OP_BL, xorshift(), xorshift(), 2'b00);
        check_comb();
        check_mem();
        // younger lane alone, nothing to squash
        @(posedge clk);
        set_lane(0, OP_OR, xorshift(), xorshift(), 2'b00);
        set_lane(1, OP_BNE, x, x, 2'b01);
        check_comb();
        check_mem();
    endtask

    task automatic test_pause_flush();
        word_t      held_res0;
        word_t      held_res1;
        logic [1:0] held_valid;
        @(posedge clk);
        set_lane(0, OP_ADD, xorshift(), xorshift(), 2'b00);
        set_lane(1, OP_XOR, xorshift(), xorshift(), 2'b00);
        check_comb();
        held_res0  = exp_res[0];
        held_res1  = exp_res[1];
        held_valid = exp_valid;
        @(posedge clk); // bundle enters the register as the pause starts
        pause <= 1'b1;
        set_lane(0, OP_BEQ, 32'h5, 32'h5, 2'b01); // mispredict held back by pause
        set_lane(1, OP_SUB, xorshift(), xorshift(), 2'b00);
        check_comb();
        @(posedge clk);
        valid <= 2'b00;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_word("mem_res0_o", mem_res0, held_res0);
            check_word("mem_res1_o", mem_res1, held_res1);
            check_bit("mem_valid_o[0]", mem_valid[0], held_valid[0]);
            check_bit("mem_valid_o[1]", mem_valid[1], held_valid[1]);
            check_bit("branch_flush_o", branch_flush, 1'b0);
        end
        @(posedge clk);
        pause <= 1'b0;
        flush <= 1'b1;
        // live lanes that the flush must keep out of the register
        set_lane(0, OP_ADD, xorshift(), xorshift(), 2'b00);
        set_lane(1, OP_OR, xorshift(), xorshift(), 2'b00);
        @(posedge clk);
        flush <= 1'b0;
        valid <= 2'b00;
        @(negedge clk);
        check_bit("mem_valid_o[0]", mem_valid[0], 1'b0);
        check_bit("mem_valid_o[1]", mem_valid[1], 1'b0);
        check_bit("mem_rd_we_o[0]", mem_rd_we[0], 1'b0);
        check_bit("mem_rd_we_o[1]", mem_rd_we[1], 1'b0);
    endtask

    initial begin
        rng_state  = 32'd80486;
        errors     = 0;
        checks     = 0;
        timed_out  = 1'b0;
        pause      = 1'b0;
        flush      = 1'b0;
        valid      = 2'b00;
        rd_we      = 2'b00;
        pred_taken = 2'b00;
        for (int l = 0; l < 2; l++) begin
            op[l]       = OP_NOP;
            pc[l]       = '0;
            src_a[l]    = '0;
            src_b[l]    = '0;
            imm[l]      = '0;
            pred_tgt[l] = '0;
            rd[l]       = '0;
        end
        wait_reset_release();
        if (!timed_out) begin
            test_reset_state();
            test_alu_random();
            test_branch_predicted();
            test_mispredict();
            test_pause_flush();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== rtl/exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu import exe_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0]; // only the low five bits count
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = a_i + b_i;
            end
            OP_SUB: begin
                result_o = a_i - b_i;
            end
            OP_AND: begin
                result_o = a_i & b_i;
            end
            OP_OR: begin
                result_o = a_i | b_i;
            end
            OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            OP_NOR: begin
                result_o = ~(a_i | b_i);
            end
            OP_SLT: begin
                result_o = {31'b0, lt_signed};
            end
            OP_SLTU: begin
                result_o = {31'b0, lt_unsigned};
            end
            OP_SLL: begin
                result_o = a_i << shamt;
            end
            OP_SRL: begin
                result_o = a_i >> shamt;
            end
            OP_SRA: begin
                result_o = word_t'($signed(a_i) >>> shamt); // keeps the sign bit
            end
            OP_LUI: begin
                result_o = b_i;
            end
            default: begin
                // nop, branches and jumps
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== rtl/exe_branch_unit.sv ====
`timescale 1ns/1ps

module exe_branch_unit import exe_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   pc_i,
    input  word_t   a_i,
    input  word_t   b_i,
    input  word_t   imm_i,
    input  logic    pred_taken_i,
    input  word_t   pred_target_i,
    output logic    is_branch_o,
    output logic    taken_o,
    output word_t   actual_target_o,
    output word_t   link_o,
    output logic    mispredict_o
);

    logic  cond;
    word_t target;
    word_t fall_through;
    logic  dir_wrong;
    logic  target_wrong;

    // branch condition, always true for jumps
    always_comb begin
        is_branch_o = 1'b1;
        cond        = 1'b0;
        case (op_i)
            OP_BEQ:  cond = (a_i == b_i);
            OP_BNE:  cond = (a_i != b_i);
            OP_BLT:  cond = ($signed(a_i) < $signed(b_i));
            OP_BGE:  cond = ($signed(a_i) >= $signed(b_i));
            OP_BLTU: cond = (a_i < b_i);
            OP_BGEU: cond = (a_i >= b_i);
            OP_B, OP_BL, OP_JIRL: begin
                cond = 1'b1;
            end
            default: begin
                is_branch_o = 1'b0;
            end
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target       = (op_i == OP_JIRL) ? (a_i + imm_i) : (pc_i + imm_i);
    assign fall_through = pc_i + INST_BYTES;
    assign link_o       = fall_through; // same as the sequential pc

    assign taken_o         = is_branch_o & cond;
    assign actual_target_o = taken_o ? target : fall_through;

    // wrong direction, or taken both ways but to a different place
    assign dir_wrong    = pred_taken_i != taken_o;
    assign target_wrong = pred_taken_i & taken_o & (pred_target_i != target);

    assign mispredict_o = is_branch_o & (dir_wrong | target_wrong);

endmodule

// ==== rtl/exe_lane.sv ====
`timescale 1ns/1ps

module exe_lane import exe_pkg::*; (
    input  logic    valid_i,
    input  alu_op_e op_i,
    input  word_t   pc_i,
    input  word_t   a_i,
    input  word_t   b_i,
    input  word_t   imm_i,
    input  logic    rd_we_i,
    input  logic    pred_taken_i,
    input  word_t   pred_target_i,
    output word_t   result_o,
    output logic    rd_we_o,
    output logic    is_branch_o,
    output logic    taken_o,
    output word_t   actual_target_o,
    output logic    mispredict_o
);

    word_t alu_result;
    word_t link;
    logic  br_is_branch;
    logic  br_mispredict;
    logic  is_link_op;

    exe_alu u_alu (
        .op_i     (op_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .result_o (alu_result)
    );

    exe_branch_unit u_branch_unit (
        .op_i            (op_i),
        .pc_i            (pc_i),
        .a_i             (a_i),
        .b_i             (b_i),
        .imm_i           (imm_i),
        .pred_taken_i    (pred_taken_i),
        .pred_target_i   (pred_target_i),
        .is_branch_o     (br_is_branch),
        .taken_o         (taken_o),
        .actual_target_o (actual_target_o),
        .link_o          (link),
        .mispredict_o    (br_mispredict)
    );

    // bl and jirl write the return address
    assign is_link_op = (op_i == OP_BL) || (op_i == OP_JIRL);
    assign result_o   = is_link_op ? link : alu_result;

    // an empty lane must not write, report or flush
    assign rd_we_o      = valid_i & rd_we_i;
    assign is_branch_o  = valid_i & br_is_branch;
    assign mispredict_o = valid_i & br_mispredict;

endmodule

// ==== rtl/exe_mem_reg.sv ====
`timescale 1ns/1ps

module exe_mem_reg import exe_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       pause_i,
    input  logic       flush_i,
    input  logic       squash1_i,  // lane 0 mispredicted
    input  logic [1:0] valid_i,
    input  alu_op_e    op0_i,
    input  alu_op_e    op1_i,
    input  word_t      pc0_i,
    input  word_t      pc1_i,
    input  logic [1:0] rd_we_i,
    input  reg_addr_t  rd0_i,
    input  reg_addr_t  rd1_i,
    input  word_t      res0_i,
    input  word_t      res1_i,
    output logic [1:0] mem_valid_o,
    output alu_op_e    mem_op0_o,
    output alu_op_e    mem_op1_o,
    output word_t      mem_pc0_o,
    output word_t      mem_pc1_o,
    output logic [1:0] mem_rd_we_o,
    output reg_addr_t  mem_rd0_o,
    output reg_addr_t  mem_rd1_o,
    output word_t      mem_res0_o,
    output word_t      mem_res1_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_valid_o <= '0;
            mem_op0_o   <= OP_NOP;
            mem_op1_o   <= OP_NOP;
            mem_pc0_o   <= '0;
            mem_pc1_o   <= '0;
            mem_rd_we_o <= '0;
            mem_rd0_o   <= '0;
            mem_rd1_o   <= '0;
            mem_res0_o  <= '0;
            mem_res1_o  <= '0;
        end else if (flush_i) begin
            // flush wins over pause
            mem_valid_o <= '0;
            mem_op0_o   <= OP_NOP;
            mem_op1_o   <= OP_NOP;
            mem_pc0_o   <= '0;
            mem_pc1_o   <= '0;
            mem_rd_we_o <= '0;
            mem_rd0_o   <= '0;
            mem_rd1_o   <= '0;
            mem_res0_o  <= '0;
            mem_res1_o  <= '0;
        end else if (!pause_i) begin
            mem_op0_o  <= op0_i;
            mem_op1_o  <= op1_i;
            mem_pc0_o  <= pc0_i;
            mem_pc1_o  <= pc1_i;
            mem_rd0_o  <= rd0_i;
            mem_rd1_o  <= rd1_i;
            mem_res0_o <= res0_i;
            mem_res1_o <= res1_i;

            // younger lane dies behind a lane 0 mispredict
            mem_valid_o[0] <= valid_i[0];
            mem_rd_we_o[0] <= rd_we_i[0];
            mem_valid_o[1] <= valid_i[1] & ~squash1_i;
            mem_rd_we_o[1] <= rd_we_i[1] & ~squash1_i;
        end
        // paused: hold
    end

endmodule

// ==== rtl/exe_pkg.sv ====
package exe_pkg;

    // data word, pc or address
    typedef logic [31:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_addr_t;

    // one op per lane, decoded upstream by dispatch
    typedef enum logic [4:0] {
        OP_NOP,
        // arithmetic and logic
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        // set on less than
        OP_SLT,
        OP_SLTU,
        // shifts by b[4:0]
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,    // b already holds the shifted immediate
        // conditional branches, pc relative
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        // unconditional
        OP_B,
        OP_BL,     // writes pc + 4
        OP_JIRL    // target is a + imm, writes pc + 4
    } alu_op_e;

    // instruction size, used for link and fall-through
    localparam word_t INST_BYTES = 32'd4;

endpackage

// ==== rtl/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    // control
    input  logic       pause_i,
    input  logic       flush_i,
    // dispatch
    input  logic [1:0] valid_i,
    input  alu_op_e    op0_i,
    input  alu_op_e    op1_i,
    input  word_t      pc0_i,
    input  word_t      pc1_i,
    input  word_t      src_a0_i,
    input  word_t      src_b0_i,
    input  word_t      src_a1_i,
    input  word_t      src_b1_i,
    input  word_t      imm0_i,
    input  word_t      imm1_i,
    input  logic [1:0] rd_we_i,
    input  reg_addr_t  rd0_i,
    input  reg_addr_t  rd1_i,
    input  logic [1:0] pred_taken_i,
    input  word_t      pred_target0_i,
    input  word_t      pred_target1_i,
    // branch predictor update
    output logic [1:0] bpu_is_branch_o,
    output logic [1:0] bpu_taken_o,
    output word_t      bpu_target0_o,
    output word_t      bpu_target1_o,
    // to control
    output logic       branch_flush_o,
    output word_t      branch_target_o,
    // forwarding to dispatch
    output logic [1:0] fwd_we_o,
    output reg_addr_t  fwd_rd0_o,
    output reg_addr_t  fwd_rd1_o,
    output word_t      fwd_data0_o,
    output word_t      fwd_data1_o,
    // to memory stage
    output logic [1:0] mem_valid_o,
    output alu_op_e    mem_op0_o,
    output alu_op_e    mem_op1_o,
    output word_t      mem_pc0_o,
    output word_t      mem_pc1_o,
    output logic [1:0] mem_rd_we_o,
    output reg_addr_t  mem_rd0_o,
    output reg_addr_t  mem_rd1_o,
    output word_t      mem_res0_o,
    output word_t      mem_res1_o
);

    logic [1:0] mispredict;

    exe_lane u_lane0 (
        .valid_i         (valid_i[0]),
        .op_i            (op0_i),
        .pc_i            (pc0_i),
        .a_i             (src_a0_i),
        .b_i             (src_b0_i),
        .imm_i           (imm0_i),
        .rd_we_i         (rd_we_i[0]),
        .pred_taken_i    (pred_taken_i[0]),
        .pred_target_i   (pred_target0_i),
        .result_o        (fwd_data0_o),
        .rd_we_o         (fwd_we_o[0]),
        .is_branch_o     (bpu_is_branch_o[0]),
        .taken_o         (bpu_taken_o[0]),
        .actual_target_o (bpu_target0_o),
        .mispredict_o    (mispredict[0])
    );

    exe_lane u_lane1 (
        .valid_i         (valid_i[1]),
        .op_i            (op1_i),
        .pc_i            (pc1_i),
        .a_i             (src_a1_i),
        .b_i             (src_b1_i),
        .imm_i           (imm1_i),
        .rd_we_i         (rd_we_i[1]),
        .pred_taken_i    (pred_taken_i[1]),
        .pred_target_i   (pred_target1_i),
        .result_o        (fwd_data1_o),
        .rd_we_o         (fwd_we_o[1]),
        .is_branch_o     (bpu_is_branch_o[1]),
        .taken_o         (bpu_taken_o[1]),
        .actual_target_o (bpu_target1_o),
        .mispredict_o    (mispredict[1])
    );

    assign fwd_rd0_o = rd0_i;
    assign fwd_rd1_o = rd1_i;

    // older lane has priority for the redirect
    assign branch_flush_o  = (|mispredict) & ~pause_i;
    assign branch_target_o = mispredict[0] ? bpu_target0_o : bpu_target1_o;

    exe_mem_reg u_exe_mem_reg (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pause_i     (pause_i),
        .flush_i     (flush_i),
        .squash1_i   (mispredict[0]),
        .valid_i     (valid_i),
        .op0_i       (op0_i),
        .op1_i       (op1_i),
        .pc0_i       (pc0_i),
        .pc1_i       (pc1_i),
        .rd_we_i     (fwd_we_o),  // already gated by valid
        .rd0_i       (rd0_i),
        .rd1_i       (rd1_i),
        .res0_i      (fwd_data0_o),
        .res1_i      (fwd_data1_o),
        .mem_valid_o (mem_valid_o),
        .mem_op0_o   (mem_op0_o),
        .mem_op1_o   (mem_op1_o),
        .mem_pc0_o   (mem_pc0_o),
        .mem_pc1_o   (mem_pc1_o),
        .mem_rd_we_o (mem_rd_we_o),
        .mem_rd0_o   (mem_rd0_o),
        .mem_rd1_o   (mem_rd1_o),
        .mem_res0_o  (mem_res0_o),
        .mem_res1_o  (mem_res1_o)
    );

endmodule
